// File: txCmdPkg.sv
`default_nettype none

package txCmdPkg;

	typedef logic [1:0] controlMode_t;	// control field of the control register
	typedef logic [15:0] pioCmd_t;
	typedef logic [31:0] irqStatus_t;

	localparam controlMode_t modeIdle = 2'b00;
	localparam controlMode_t modePio = 2'b01;	// commands taken from the PIO word

	// command word, one command per bit
	localparam int cmdIssueRcvTrig = 1;
	localparam int cmdFire = 2;
	localparam int cmdSetAmp = 5;	// charge time and temporary fire mask
	localparam int cmdSetPhase = 6;
	localparam int cmdResetRcvTrig = 13;
	localparam int cmdResetInterrupt = 14;

	// interrupt status word
	localparam int stDone = 0;
	localparam int stNewCmd = 1;
	localparam int stFireAccepted = 4;
	localparam int stSetAmp = 5;
	localparam int stSetPhase = 6;
	localparam int stRcvAccepted = 8;
	localparam int stFireDelayDone = 9;
	localparam int stFireComplete = 10;
	localparam int stAdcRaised = 12;

	typedef enum logic [1:0]
	{
		seqIdle,
		seqFireDelay,	// counting down the fire delay
		seqArmed,		// channels armed, waiting for all chanDone
		seqClear
	} seqState_t;

endpackage

`default_nettype wire

// File: txChanPkg.sv
`default_nettype none

package txChanPkg;

	// pulse width in clock cycles
	typedef logic [8:0] chargeTime_t;

	// per-channel wait between trigger and pulse
	typedef logic [15:0] phaseDelay_t;

	// fire delay and receive-trigger delay
	typedef logic [31:0] delayCount_t;

endpackage

`default_nettype wire

// File: txChannel.sv
`default_nettype none
`timescale 1ns/100ps

module txChannel (
	input logic txCLK,
	input logic rst,
	input logic chanClear,
	input logic chanEnable,
	input logic chanArm,
	input logic fireTrigger,
	input txChanPkg::chargeTime_t chargeTime,
	input txChanPkg::phaseDelay_t phaseDelay,
	output logic transducerOut,
	output logic chanDone
);

	import txChanPkg::*;

	phaseDelay_t waitCount;
	chargeTime_t pulseCount;
	logic waiting;
	logic pulsing;
	logic fireSeen;
	logic pulseStart;

	// trigger while armed, once per fire
	assign fireSeen = chanArm & fireTrigger & ~waiting & ~pulsing & ~chanDone;
	assign pulseStart = (fireSeen & chanEnable & (phaseDelay == '0))
		| (waiting & (waitCount == '0));
	assign transducerOut = pulsing;

	always_ff @(posedge txCLK)
	begin
		if (rst || chanClear)
		begin
			waiting <= 1'b0;
			pulsing <= 1'b0;
			chanDone <= 1'b0;
		end
		else
		begin
			if (fireSeen && !chanEnable)
				chanDone <= 1'b1;	// disabled, done at once
			else if (fireSeen && phaseDelay != '0)
				waiting <= 1'b1;

			if (pulseStart)
			begin
				waiting <= 1'b0;
				if (chargeTime == '0)
					chanDone <= 1'b1;	// zero charge time gives no pulse
				else
					pulsing <= 1'b1;
			end
			else if (pulsing && pulseCount == '0)
			begin
				pulsing <= 1'b0;
				chanDone <= 1'b1;
			end
		end
	end

	// pulse rises phaseDelay edges after the trigger edge, lasts chargeTime cycles
	always_ff @(posedge txCLK)
	begin
		if (fireSeen)
			waitCount <= phaseDelay - 1'b1;
		else if (waiting)
			waitCount <= waitCount - 1'b1;

		if (pulseStart)
			pulseCount <= chargeTime - 1'b1;
		else if (pulsing)
			pulseCount <= pulseCount - 1'b1;
	end

endmodule

`default_nettype wire

// File: rcvTrigger.sv
`default_nettype none
`timescale 1ns/100ps

module rcvTrigger (
	input logic txCLK,
	input logic rst,
	input logic rcvStart,
	input logic rcvClear,
	input txChanPkg::delayCount_t rcvDelay,
	input logic adcTriggerAck,
	output logic adcTrigger,
	output logic rcvBusy,
	output logic adcRaised
);

	import txChanPkg::*;

	delayCount_t count;
	logic counting;

	assign rcvBusy = counting | adcTrigger;	// countdown or waiting for the ack

	always_ff @(posedge txCLK)
	begin
		if (rst || rcvClear)
		begin
			counting <= 1'b0;
			adcTrigger <= 1'b0;
			adcRaised <= 1'b0;
		end
		else
		begin
			adcRaised <= 1'b0;
			if (rcvStart && !rcvBusy)
			begin
				counting <= 1'b1;
				count <= rcvDelay;
			end
			else if (counting)
			begin
				// trigger rises rcvDelay+1 edges after the start edge
				if (count != '0)
					count <= count - 1'b1;
				else
				begin
					counting <= 1'b0;
					adcTrigger <= 1'b1;
					adcRaised <= 1'b1;
				end
			end
			else if (adcTrigger && adcTriggerAck)
				adcTrigger <= 1'b0;	// drop on the edge after the ack is seen
		end
	end

endmodule

`default_nettype wire

// File: txSequencer.sv
`default_nettype none
`timescale 1ns/100ps

module txSequencer #(
	parameter int numChannels = 8
) (
	input logic txCLK,
	input logic rst,
	input txCmdPkg::controlMode_t controlMode,
	input txCmdPkg::pioCmd_t pioCommands,
	input logic soloMode,
	input logic extTrigMode,
	input logic extTrigger,
	input logic [numChannels-1:0] chanEnable,
	input logic [numChannels-1:0] fireMask,
	input txChanPkg::chargeTime_t chargeTime,
	input txChanPkg::phaseDelay_t [numChannels-1:0] phaseDelays,
	input txChanPkg::delayCount_t fireDelay,
	input txChanPkg::delayCount_t rcvDelay,
	input logic [numChannels-1:0] chanDone,
	input logic rcvBusy,
	input logic adcRaised,
	output logic chanArm,
	output logic chanClear,
	output logic fireTrigger,
	output logic [numChannels-1:0] chanEnableMasked,
	output txChanPkg::chargeTime_t chanChargeTime,
	output txChanPkg::phaseDelay_t [numChannels-1:0] chanPhaseDelays,
	output logic rcvStart,
	output txChanPkg::delayCount_t rcvTrigDelay,
	output logic rcvClear,
	output txCmdPkg::irqStatus_t interruptStatus
);

	import txCmdPkg::*;
	import txChanPkg::*;

	seqState_t state;
	pioCmd_t cmdReg;					// input register for the command word
	pioCmd_t prevCmd;					// last captured command word
	delayCount_t fireCount;
	logic [numChannels-1:0] tmpMask;	// set bit masks a channel until the fire completes
	logic internalTrig;
	logic cmdAccepted;					// some command taken since the last clear

	logic idleMode;
	logic pioMode;
	logic cmdValid;
	logic fireBusy;
	logic useInternal;
	logic trigSel;
	logic acceptFire;
	logic acceptAmp;
	logic acceptPhase;
	logic acceptRcv;

	assign idleMode = (controlMode == modeIdle);
	assign pioMode = (controlMode == modePio);
	assign cmdValid = pioMode & (cmdReg != prevCmd);	// act on changes only
	assign fireBusy = (state != seqIdle);
	assign useInternal = soloMode & ~extTrigMode;	// solo board, no external trigger
	assign trigSel = useInternal ? internalTrig : extTrigger;
	assign chanEnableMasked = chanEnable & ~tmpMask;

	// fire, amp and phase wait until a running fire is over
	assign acceptFire = cmdValid & cmdReg[cmdFire] & ~fireBusy;
	assign acceptAmp = cmdValid & cmdReg[cmdSetAmp] & ~fireBusy;
	assign acceptPhase = cmdValid & cmdReg[cmdSetPhase] & ~fireBusy;
	assign acceptRcv = cmdValid & cmdReg[cmdIssueRcvTrig] & ~rcvBusy & ~rcvStart;

	always_ff @(posedge txCLK)
	begin
		if (rst)
			cmdReg <= '0;
		else
			cmdReg <= pioCommands;
	end

	always_ff @(posedge txCLK)
	begin
		if (acceptAmp)
			chanChargeTime <= chargeTime;
		if (acceptPhase)
			chanPhaseDelays <= phaseDelays;
		if (acceptRcv)
			rcvTrigDelay <= rcvDelay;	// valid while rcvStart is high
	end

	always_ff @(posedge txCLK)
	begin
		chanClear <= 1'b0;
		rcvStart <= 1'b0;
		rcvClear <= 1'b0;
		if (rst || idleMode)
		begin
			state <= seqIdle;
			prevCmd <= '0;
			fireCount <= '0;
			tmpMask <= '0;
			internalTrig <= 1'b0;
			cmdAccepted <= 1'b0;
			chanArm <= 1'b0;
			fireTrigger <= 1'b0;
			interruptStatus <= '0;
			chanClear <= idleMode;	// keeps channels and receive trigger quiet in idle
			rcvClear <= idleMode;
		end
		else if (pioMode)
		begin
			unique case (state)
				seqIdle:
				begin
					if (acceptFire)
					begin
						fireCount <= fireDelay;
						state <= seqFireDelay;
					end
				end
				seqFireDelay:
				begin
					if (fireCount != '0)
						fireCount <= fireCount - 1'b1;
					else
					begin
						state <= seqArmed;
						chanArm <= 1'b1;
						fireTrigger <= trigSel;	// internal trigger rises with chanArm
						interruptStatus[stFireDelayDone] <= 1'b1;
					end
				end
				seqArmed:
				begin
					if (&chanDone)
					begin
						state <= seqClear;
						chanArm <= 1'b0;
						fireTrigger <= 1'b0;
						chanClear <= 1'b1;
						tmpMask <= '0;	// back to the full enable set
						interruptStatus[stFireComplete] <= 1'b1;
					end
					else
						fireTrigger <= trigSel;
				end
				seqClear:
					state <= seqIdle;	// channels drop chanDone on this edge
				default:
					state <= seqIdle;
			endcase

			if (cmdValid)
			begin
				prevCmd <= cmdReg;
				interruptStatus[stNewCmd] <= 1'b1;
			end
			if (acceptFire)
			begin
				interruptStatus[stFireAccepted] <= 1'b1;
				if (useInternal)
					internalTrig <= 1'b1;
			end
			if (acceptAmp)
			begin
				tmpMask <= fireMask;
				interruptStatus[stSetAmp] <= 1'b1;
			end
			if (acceptPhase)
				interruptStatus[stSetPhase] <= 1'b1;
			if (acceptRcv)
			begin
				rcvStart <= 1'b1;
				interruptStatus[stRcvAccepted] <= 1'b1;
			end
			if (acceptFire || acceptAmp || acceptPhase || acceptRcv)
				cmdAccepted <= 1'b1;
			if (cmdValid && cmdReg[cmdResetRcvTrig])
				rcvClear <= 1'b1;
			if (adcRaised)
				interruptStatus[stAdcRaised] <= 1'b1;

			// nothing left running
			if (cmdAccepted && !chanArm && state != seqFireDelay && !acceptFire
				&& !rcvBusy && !rcvStart && !acceptRcv)
				interruptStatus[stDone] <= 1'b1;

			// last so it wins over every bit set above
			if (cmdValid && cmdReg[cmdResetInterrupt])
			begin
				interruptStatus <= '0;
				internalTrig <= 1'b0;
				cmdAccepted <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: txOutputCtrl.sv
`default_nettype none
`timescale 1ns/100ps

module txOutputCtrl #(
	parameter int numChannels = 8
) (
	input logic txCLK,
	input logic rst,
	input txCmdPkg::controlMode_t controlMode,
	input txCmdPkg::pioCmd_t pioCommands,
	input logic soloMode,
	input logic extTrigMode,
	input logic [numChannels-1:0] chanEnable,
	input logic [numChannels-1:0] fireMask,
	input txChanPkg::chargeTime_t chargeTime,
	input txChanPkg::phaseDelay_t [numChannels-1:0] phaseDelays,
	input txChanPkg::delayCount_t fireDelay,
	input txChanPkg::delayCount_t rcvDelay,
	input logic extTrigger,
	input logic adcTriggerAck,
	output logic [numChannels-1:0] transducerOut,
	output logic adcTrigger,
	output txCmdPkg::irqStatus_t interruptStatus
);

	import txChanPkg::*;

	logic chanArm;
	logic chanClear;
	logic fireTrigger;
	logic [numChannels-1:0] chanEnableMasked;
	logic [numChannels-1:0] chanDone;
	chargeTime_t chanChargeTime;
	phaseDelay_t [numChannels-1:0] chanPhaseDelays;
	logic rcvStart;
	logic rcvClear;
	logic rcvBusy;
	logic adcRaised;
	delayCount_t rcvTrigDelay;	// delay captured with the issue command

	txSequencer #(
		.numChannels(numChannels)
	) seqInst (
		.txCLK(txCLK),
		.rst(rst),
		.controlMode(controlMode),
		.pioCommands(pioCommands),
		.soloMode(soloMode),
		.extTrigMode(extTrigMode),
		.extTrigger(extTrigger),
		.chanEnable(chanEnable),
		.fireMask(fireMask),
		.chargeTime(chargeTime),
		.phaseDelays(phaseDelays),
		.fireDelay(fireDelay),
		.rcvDelay(rcvDelay),
		.chanDone(chanDone),
		.rcvBusy(rcvBusy),
		.adcRaised(adcRaised),
		.chanArm(chanArm),
		.chanClear(chanClear),
		.fireTrigger(fireTrigger),
		.chanEnableMasked(chanEnableMasked),
		.chanChargeTime(chanChargeTime),
		.chanPhaseDelays(chanPhaseDelays),
		.rcvStart(rcvStart),
		.rcvTrigDelay(rcvTrigDelay),
		.rcvClear(rcvClear),
		.interruptStatus(interruptStatus)
	);

	for (genvar i = 0; i < numChannels; i++)
	begin : genChan
		txChannel chanInst (
			.txCLK(txCLK),
			.rst(rst),
			.chanClear(chanClear),
			.chanEnable(chanEnableMasked[i]),
			.chanArm(chanArm),
			.fireTrigger(fireTrigger),
			.chargeTime(chanChargeTime),
			.phaseDelay(chanPhaseDelays[i]),
			.transducerOut(transducerOut[i]),
			.chanDone(chanDone[i])
		);
	end

	rcvTrigger rcvInst (
		.txCLK(txCLK),
		.rst(rst),
		.rcvStart(rcvStart),
		.rcvClear(rcvClear),
		.rcvDelay(rcvTrigDelay),
		.adcTriggerAck(adcTriggerAck),
		.adcTrigger(adcTrigger),
		.rcvBusy(rcvBusy),
		.adcRaised(adcRaised)
	);

endmodule

`default_nettype wire

// File: txOutputCtrl_sva.sv
`default_nettype none
`timescale 1ns/100ps

module txOutputCtrl_sva (
	input logic txCLK,
	input logic rst,
	input logic arm,
	input logic enable,
	input logic pulse,
	input logic trig,
	input logic ack,
	input logic abort
);

	pulseNeedsArm: assert property (@(posedge txCLK) disable iff (rst)
		$rose(pulse) |-> arm)
		else $error("transducer pulse started without chanArm");

	// abort covers the reset-receive command and idle mode
	trigHeldUntilAck: assert property (@(posedge txCLK) disable iff (rst)
		(trig && !ack && !abort) |=> trig)
		else $error("adcTrigger dropped before acknowledge");

	quietWhenDisabled: assert property (@(posedge txCLK) disable iff (rst)
		!enable |-> !pulse)
		else $error("transducerOut high on a disabled channel");

endmodule

bind txChannel txOutputCtrl_sva chanChecks (
	.txCLK(txCLK),
	.rst(rst),
	.arm(chanArm),
	.enable(chanEnable),
	.pulse(transducerOut),
	.trig(1'b0),
	.ack(1'b0),
	.abort(1'b0)
);

bind rcvTrigger txOutputCtrl_sva rcvChecks (
	.txCLK(txCLK),
	.rst(rst),
	.arm(1'b1),
	.enable(1'b1),
	.pulse(1'b0),
	.trig(adcTrigger),
	.ack(adcTriggerAck),
	.abort(rcvClear)
);

`default_nettype wire

// File: txOutputCtrlTb.sv
`default_nettype none
`timescale 1ns/100ps

module txOutputCtrlTb;

	import txCmdPkg::*;
	import txChanPkg::*;

	localparam int numChannels = 8;

	logic txCLK;
	logic rst;
	controlMode_t controlMode;
	pioCmd_t pioCommands;
	logic soloMode;
	logic extTrigMode;
	logic [numChannels-1:0] chanEnable;
	logic [numChannels-1:0] fireMask;
	chargeTime_t chargeTime;
	phaseDelay_t [numChannels-1:0] phaseDelays;
	delayCount_t fireDelay;
	delayCount_t rcvDelay;
	logic extTrigger;
	logic adcTriggerAck;
	logic [numChannels-1:0] transducerOut;
	logic adcTrigger;
	irqStatus_t interruptStatus;

	logic [31:0] lfsrState;
	irqStatus_t expStatus;	// model of the interrupt word
	pioCmd_t lastCmd;		// last word the DUT should have captured
	chargeTime_t ampTime;	// charge time taken by the last set-amp
	int cycle;
	int riseAt [numChannels];
	int riseCount [numChannels];
	int highCount [numChannels];
	logic [numChannels-1:0] prevOut;

	txOutputCtrl #(
		.numChannels(numChannels)
	) txOutputCtrl_inst (
		.txCLK(txCLK),
		.rst(rst),
		.controlMode(controlMode),
		.pioCommands(pioCommands),
		.soloMode(soloMode),
		.extTrigMode(extTrigMode),
		.chanEnable(chanEnable),
		.fireMask(fireMask),
		.chargeTime(chargeTime),
		.phaseDelays(phaseDelays),
		.fireDelay(fireDelay),
		.rcvDelay(rcvDelay),
		.extTrigger(extTrigger),
		.adcTriggerAck(adcTriggerAck),
		.transducerOut(transducerOut),
		.adcTrigger(adcTrigger),
		.interruptStatus(interruptStatus)
	);

	initial
	begin
		txCLK = 1'b0;
		forever #20 txCLK = ~txCLK;
	end

	// pulse log, sampled on the falling edge
	always @(negedge txCLK)
	begin
		cycle++;
		for (int i = 0; i < numChannels; i++)
		begin
			if (transducerOut[i])
			begin
				highCount[i]++;
				if (!prevOut[i])
				begin
					riseAt[i] = cycle;
					riseCount[i]++;
				end
			end
		end
		prevOut = transducerOut;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++)
		begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};	// one step per bit
		end
		return r;
	endfunction

	function automatic pioCmd_t cmdBit(input int pos);
		return pioCmd_t'(1) << pos;
	endfunction

	// status once the command has run to its end
	function automatic irqStatus_t refStatus(input irqStatus_t prev, input pioCmd_t cmd,
		input pioCmd_t last);
		irqStatus_t s;
		s = prev;
		if (cmd == last)
			return prev;	// unchanged word is not a command
		if (cmd[cmdResetInterrupt])
			return '0;
		s[stNewCmd] = 1'b1;
		if (cmd[cmdSetPhase])
			s[stSetPhase] = 1'b1;
		if (cmd[cmdSetAmp])
			s[stSetAmp] = 1'b1;
		if (cmd[cmdFire])
		begin
			s[stFireAccepted] = 1'b1;
			s[stFireDelayDone] = 1'b1;
			s[stFireComplete] = 1'b1;
		end
		if (cmd[cmdIssueRcvTrig])
		begin
			s[stRcvAccepted] = 1'b1;
			s[stAdcRaised] = 1'b1;
		end
		s[stDone] = s[stFireAccepted] | s[stSetAmp] | s[stSetPhase] | s[stRcvAccepted];
		return s;
	endfunction

	function automatic int refWidth(input logic enabled, input logic masked,
		input chargeTime_t ct);
		return (enabled && !masked) ? int'(ct) : 0;
	endfunction

	function automatic int refOffset(input phaseDelay_t a, input phaseDelay_t b);
		return int'(a) - int'(b);
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic failNow(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "timeout");
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge txCLK);
	endtask

	task automatic waitStatusBit(input int pos, input int limit, input string what);
		int n;
		n = 0;
		do
		begin
			@(negedge txCLK);
			n++;
		end while (interruptStatus[pos] !== 1'b1 && n < limit);
		if (interruptStatus[pos] !== 1'b1)
			failNow(what);
	endtask

	task automatic waitAdcLevel(input logic level, input int limit, input string what);
		int n;
		n = 0;
		do
		begin
			@(negedge txCLK);
			n++;
		end while (adcTrigger !== level && n < limit);
		if (adcTrigger !== level)
			failNow(what);
	endtask

	task automatic sendCmd(input pioCmd_t cmd);
		@(posedge txCLK);
		pioCommands <= cmd;
		expStatus = refStatus(expStatus, cmd, lastCmd);
		lastCmd = cmd;
	endtask

	task automatic clearLog();
		for (int i = 0; i < numChannels; i++)
		begin
			riseAt[i] = 0;
			riseCount[i] = 0;
			highCount[i] = 0;
		end
		prevOut = '0;
	endtask

	task automatic clearInterrupt();
		sendCmd(cmdBit(cmdResetInterrupt));
		idleCycles(3);	// registered, then acted on
		checkEq("interruptStatus", interruptStatus, expStatus);
	endtask

	task automatic checkPulses(input logic useMask);
		int refChan;
		int w;
		refChan = -1;
		for (int i = 0; i < numChannels; i++)
		begin
			w = refWidth(chanEnable[i], useMask && fireMask[i], ampTime);
			checkEq($sformatf("transducerOut[%0d] width", i), highCount[i], w);
			if (w != 0)
			begin
				checkEq($sformatf("transducerOut[%0d] pulses", i), riseCount[i], 1);
				if (refChan < 0)
					refChan = i;	// first firing channel is the reference
				else
					checkEq($sformatf("transducerOut[%0d] offset", i),
						riseAt[i] - riseAt[refChan],
						refOffset(phaseDelays[i], phaseDelays[refChan]));
			end
		end
	endtask

	task automatic runFire(input logic useMask, input logic extMode);
		clearInterrupt();
		clearLog();
		sendCmd(cmdBit(cmdFire));
		if (extMode)
		begin
			waitStatusBit(stFireDelayDone, 200, "fire delay never finished");
			for (int c = 0; c < 80; c++)
			begin
				@(negedge txCLK);
				checkEq("transducerOut", transducerOut, '0);	// armed, no trigger yet
			end
			@(posedge txCLK);
			extTrigger <= 1'b1;
		end
		waitStatusBit(stFireComplete, 500, "fire never completed");
		waitStatusBit(stDone, 10, "done bit not set after the fire");
		checkEq("interruptStatus", interruptStatus, expStatus);
		checkPulses(useMask);
		@(posedge txCLK);
		extTrigger <= 1'b0;
	endtask

	initial
	begin
		lfsrState = 32'h18a7;
		rst = 1'b1;
		controlMode = modeIdle;
		pioCommands = '0;
		soloMode = 1'b1;
		extTrigMode = 1'b0;
		chanEnable = '0;
		fireMask = '0;
		chargeTime = '0;
		phaseDelays = '0;
		fireDelay = 32'd12;
		rcvDelay = 32'd10;
		extTrigger = 1'b0;
		adcTriggerAck = 1'b0;
		expStatus = '0;
		lastCmd = '0;
		ampTime = '0;
		clearLog();
		repeat (3) @(posedge txCLK);
		rst <= 1'b0;

		@(negedge txCLK);
		checkEq("transducerOut", transducerOut, '0);
		checkEq("adcTrigger", adcTrigger, '0);
		checkEq("interruptStatus", interruptStatus, '0);
		@(posedge txCLK);
		controlMode <= modePio;

		@(posedge txCLK);
		for (int i = 0; i < numChannels; i++)
			phaseDelays[i] <= phaseDelay_t'(randBits(6));
		chargeTime <= chargeTime_t'(randBits(5) + 32'd1);	// never zero
		chanEnable <= numChannels'(randBits(numChannels) | 32'h1);
		fireMask <= numChannels'(randBits(numChannels) & ~32'h1);	// channel 0 always fires

		sendCmd(cmdBit(cmdSetPhase));
		waitStatusBit(stSetPhase, 10, "set-phase command not taken");
		waitStatusBit(stDone, 10, "done bit not set after set-phase");
		checkEq("interruptStatus", interruptStatus, expStatus);
		sendCmd(cmdBit(cmdSetAmp));
		waitStatusBit(stSetAmp, 10, "set-amp command not taken");
		checkEq("interruptStatus", interruptStatus, expStatus);
		ampTime = chargeTime;

		// same word again with a new charge time, which must not be taken
		@(posedge txCLK);
		chargeTime <= chargeTime + 1'b1;
		sendCmd(cmdBit(cmdSetAmp));
		idleCycles(4);
		checkEq("interruptStatus", interruptStatus, expStatus);

		runFire(1'b1, 1'b0);
		runFire(1'b0, 1'b0);	// mask restored after the first fire
		@(posedge txCLK);
		extTrigMode <= 1'b1;
		runFire(1'b0, 1'b1);
		@(posedge txCLK);
		extTrigMode <= 1'b0;

		clearInterrupt();
		sendCmd(cmdBit(cmdIssueRcvTrig));
		waitAdcLevel(1'b1, 100, "adcTrigger never rose");
		waitStatusBit(stAdcRaised, 5, "adc raised bit not set");
		sendCmd(cmdBit(cmdIssueRcvTrig) | 16'h0001);	// new word, issue again while held
		for (int c = 0; c < 8; c++)
		begin
			@(negedge txCLK);
			checkEq("adcTrigger", adcTrigger, 1);
		end
		@(posedge txCLK);
		adcTriggerAck <= 1'b1;
		@(negedge txCLK);
		checkEq("adcTrigger", adcTrigger, 1);
		@(negedge txCLK);
		checkEq("adcTrigger", adcTrigger, 0);
		@(posedge txCLK);
		adcTriggerAck <= 1'b0;
		waitStatusBit(stDone, 10, "done bit not set after the receive trigger");
		checkEq("interruptStatus", interruptStatus, expStatus);

		sendCmd(cmdBit(cmdIssueRcvTrig));
		waitAdcLevel(1'b1, 100, "adcTrigger never rose for the reset test");
		sendCmd(cmdBit(cmdResetRcvTrig));
		waitAdcLevel(1'b0, 4, "reset-receive command did not drop adcTrigger");
		idleCycles(2);
		checkEq("interruptStatus", interruptStatus, expStatus);

		clearInterrupt();

		// idle mode with the trigger held
		sendCmd(cmdBit(cmdIssueRcvTrig));
		waitAdcLevel(1'b1, 100, "adcTrigger never rose before idle");
		@(posedge txCLK);
		controlMode <= modeIdle;
		idleCycles(3);
		checkEq("transducerOut", transducerOut, '0);
		checkEq("adcTrigger", adcTrigger, '0);
		checkEq("interruptStatus", interruptStatus, '0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: txOutputCtrl.f
txCmdPkg.sv
txChanPkg.sv
txChannel.sv
rcvTrigger.sv
txSequencer.sv
txOutputCtrl.sv
txOutputCtrl_sva.sv
txOutputCtrlTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module txOutputCtrlTb \
	-f txOutputCtrl.f \
	-o txOutputCtrlSim

./obj_dir/txOutputCtrlSim
